// ==== hdl/udp_loopback_pkg.sv ====
// ========================================
// Fixed 512-bit beat and 42-byte header that sits whole in the first beat
// Header layout is Ethernet II + IPv4 with no options + UDP
// ========================================
package udp_loopback_pkg;

  // Beat geometry
  localparam int DATA_W = 512;
  localparam int KEEP_W = DATA_W / 8;

  // Register stages on the return path
  localparam int FIFO_REGS = 4;

  // Protocol constants
  localparam logic [15:0] LOOPBACK_PORT  = 16'd1234;
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

  // Byte offsets in the first beat, byte n at tdata[8n+7:8n]
  localparam int OFS_DST_MAC   = 0;
  localparam int OFS_SRC_MAC   = 6;
  localparam int OFS_ETHERTYPE = 12;
  localparam int OFS_IP_PROTO  = 23;
  localparam int OFS_SRC_IP    = 26;
  localparam int OFS_DST_IP    = 30;
  localparam int OFS_SRC_PORT  = 34;
  localparam int OFS_DST_PORT  = 36;

  // Field lengths used by the address swap
  localparam int MAC_BYTES     = 6;
  localparam int IP_ADDR_BYTES = 4;
  localparam int PORT_BYTES    = 2;

  // Header length, also the offset of the first payload byte
  localparam int HDR_BYTES = 42;

endpackage

// ==== hdl/axis_if.sv ====
// ========================================
// AXI-Stream link, one beat per valid/ready transfer
// tuser is a single error flag as delivered by the MAC
// ========================================
`timescale 1ns/1ps

interface axis_if import udp_loopback_pkg::*; ();

  logic [DATA_W-1:0] tdata;
  logic [KEEP_W-1:0] tkeep;
  logic              tvalid;
  logic              tready;
  logic              tlast;
  logic              tuser;

  modport source (
    output tdata, tkeep, tvalid, tlast, tuser,
    input  tready
  );

  modport sink (
    input  tdata, tkeep, tvalid, tlast, tuser,
    output tready
  );

endinterface

// ==== hdl/udp_port_filter.sv ====
// ========================================
// Judges a frame on its first beat only; decision holds until tlast
// Dropped frames are consumed at full rate, matches pass one register
// ========================================
`timescale 1ns/1ps

module udp_port_filter import udp_loopback_pkg::*; (
  input logic   clk,
  input logic   rst,
  axis_if.sink   in_s,
  axis_if.source out_m
);

  logic              first_beat;
  logic              match_reg;
  logic              match_now;
  logic              fwd;
  logic              xfer_in;
  logic              load;

  logic              out_valid;
  logic [DATA_W-1:0] out_data;
  logic [KEEP_W-1:0] out_keep;
  logic              out_last;
  logic              out_user;

  // Big-endian 16-bit field starting at byte ofs
  function automatic logic [15:0] field16(input logic [DATA_W-1:0] d, input int ofs);
    return {d[8*ofs +: 8], d[8*(ofs+1) +: 8]};
  endfunction

  // IPv4 UDP to the loopback port, with the whole header present
  assign match_now = (field16(in_s.tdata, OFS_ETHERTYPE) == ETHERTYPE_IPV4) &&
                     (in_s.tdata[8*OFS_IP_PROTO +: 8] == IP_PROTO_UDP) &&
                     (field16(in_s.tdata, OFS_DST_PORT) == LOOPBACK_PORT) &&
                     (&in_s.tkeep[HDR_BYTES-1:0]);

  // First beat decides for itself, later beats follow the stored decision
  assign fwd = first_beat ? match_now : match_reg;

  // Dropped beats never wait
  assign in_s.tready = fwd ? (!out_valid || out_m.tready) : 1'b1;

  assign xfer_in = in_s.tvalid && in_s.tready;
  assign load    = xfer_in && fwd;

  always_ff @(posedge clk) begin
    if (rst) begin
      first_beat <= 1'b1;
      match_reg  <= 1'b0;
      out_valid  <= 1'b0;
    end else begin
      if (xfer_in) begin
        first_beat <= in_s.tlast;
        if (first_beat) begin
          match_reg <= match_now;
        end
      end
      if (load) begin
        out_valid <= 1'b1;
      end else if (out_m.tready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= in_s.tdata;
      out_keep <= in_s.tkeep;
      out_last <= in_s.tlast;
      out_user <= in_s.tuser;
    end
  end

  assign out_m.tvalid = out_valid;
  assign out_m.tdata  = out_data;
  assign out_m.tkeep  = out_keep;
  assign out_m.tlast  = out_last;
  assign out_m.tuser  = out_user;

  // A stalled output beat is held until the next stage takes it
  a_out_stable: assert property (
    @(posedge clk) disable iff (rst)
    (out_m.tvalid && !out_m.tready) |=> (out_m.tvalid && $stable(out_m.tdata))
  );

endmodule

// ==== hdl/axis_reg_stage.sv ====
// ========================================
// Two-entry skid slice with tready straight from a flop
// Sustains one beat per cycle with one cycle of latency
// ========================================
`timescale 1ns/1ps

module axis_reg_stage import udp_loopback_pkg::*; (
  input logic   clk,
  input logic   rst,
  axis_if.sink   in_s,
  axis_if.source out_m
);

  logic              m_valid;
  logic [DATA_W-1:0] m_data;
  logic [KEEP_W-1:0] m_keep;
  logic              m_last;
  logic              m_user;

  logic              s_valid;
  logic [DATA_W-1:0] s_data;
  logic [KEEP_W-1:0] s_keep;
  logic              s_last;
  logic              s_user;

  logic              accept;
  logic              m_free;

  // Ready while the skid entry is empty
  assign in_s.tready = !s_valid;
  assign accept      = in_s.tvalid && !s_valid;

  // Main entry empties or moves on this edge
  assign m_free = !m_valid || out_m.tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid <= 1'b0;
      s_valid <= 1'b0;
    end else if (m_free) begin
      m_valid <= s_valid || accept;
      s_valid <= 1'b0;
    end else if (accept) begin
      s_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (m_free) begin
      if (s_valid) begin
        m_data <= s_data;
        m_keep <= s_keep;
        m_last <= s_last;
        m_user <= s_user;
      end else if (accept) begin
        m_data <= in_s.tdata;
        m_keep <= in_s.tkeep;
        m_last <= in_s.tlast;
        m_user <= in_s.tuser;
      end
    end else if (accept) begin
      // Park the incoming beat while the output is stalled
      s_data <= in_s.tdata;
      s_keep <= in_s.tkeep;
      s_last <= in_s.tlast;
      s_user <= in_s.tuser;
    end
  end

  assign out_m.tvalid = m_valid;
  assign out_m.tdata  = m_data;
  assign out_m.tkeep  = m_keep;
  assign out_m.tlast  = m_last;
  assign out_m.tuser  = m_user;

  // A parked beat stays put until the main entry frees
  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst)
    (s_valid && !out_m.tready) |=> (s_valid && $stable(s_data))
  );

endmodule

// ==== hdl/loopback_responder.sv ====
// ========================================
// Swaps MAC, IP and UDP port pairs on the first beat of every frame
// IP checksum is unchanged since the swap keeps the ones-complement sum
// ========================================
`timescale 1ns/1ps

module loopback_responder import udp_loopback_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  axis_if.sink       in_s,
  axis_if.source     out_m,
  output logic [7:0] led
);

  logic              in_first;
  logic              out_first;
  logic              load;
  logic              xfer_out;
  logic [DATA_W-1:0] swapped;

  logic              out_valid;
  logic [DATA_W-1:0] out_data;
  logic [KEEP_W-1:0] out_keep;
  logic              out_last;
  logic              out_user;

  // Return-path header, sender and receiver fields exchanged
  function automatic logic [DATA_W-1:0] swap_hdr(input logic [DATA_W-1:0] d);
    logic [DATA_W-1:0] r;
    int i;
    r = d;
    for (i = 0; i < MAC_BYTES; i++) begin
      r[8*(OFS_DST_MAC+i) +: 8] = d[8*(OFS_SRC_MAC+i) +: 8];
      r[8*(OFS_SRC_MAC+i) +: 8] = d[8*(OFS_DST_MAC+i) +: 8];
    end
    for (i = 0; i < IP_ADDR_BYTES; i++) begin
      r[8*(OFS_SRC_IP+i) +: 8] = d[8*(OFS_DST_IP+i) +: 8];
      r[8*(OFS_DST_IP+i) +: 8] = d[8*(OFS_SRC_IP+i) +: 8];
    end
    for (i = 0; i < PORT_BYTES; i++) begin
      r[8*(OFS_SRC_PORT+i) +: 8] = d[8*(OFS_DST_PORT+i) +: 8];
      r[8*(OFS_DST_PORT+i) +: 8] = d[8*(OFS_SRC_PORT+i) +: 8];
    end
    return r;
  endfunction

  assign in_s.tready = !out_valid || out_m.tready;
  assign load        = in_s.tvalid && in_s.tready;
  assign xfer_out    = out_valid && out_m.tready;

  // Payload beats pass untouched
  assign swapped = in_first ? swap_hdr(in_s.tdata) : in_s.tdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_first  <= 1'b1;
      out_first <= 1'b1;
      out_valid <= 1'b0;
      led       <= 8'd0;
    end else begin
      if (load) begin
        in_first <= in_s.tlast;
      end
      if (xfer_out) begin
        out_first <= out_last;
        // First payload byte of the frame just sent
        if (out_first) begin
          led <= out_data[8*HDR_BYTES +: 8];
        end
      end
      if (load) begin
        out_valid <= 1'b1;
      end else if (out_m.tready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= swapped;
      out_keep <= in_s.tkeep;
      out_last <= in_s.tlast;
      out_user <= in_s.tuser;
    end
  end

  assign out_m.tvalid = out_valid;
  assign out_m.tdata  = out_data;
  assign out_m.tkeep  = out_keep;
  assign out_m.tlast  = out_last;
  assign out_m.tuser  = out_user;

  // LED only follows frame starts leaving the core
  a_led_on_first: assert property (
    @(posedge clk) disable iff (rst)
    !(xfer_out && out_first) |=> $stable(led)
  );

endmodule

// ==== hdl/udp_loopback_top.sv ====
// ========================================
// UDP loopback on one 512-bit MAC stream, single clock domain
// Latency is FIFO_REGS+2 cycles without back-pressure
// ========================================
`timescale 1ns/1ps

module udp_loopback_top import udp_loopback_pkg::*; (
  input  logic              clk,
  input  logic              rst,

  // Receive stream from the MAC
  input  logic [DATA_W-1:0] rx_tdata,
  input  logic [KEEP_W-1:0] rx_tkeep,
  input  logic              rx_tvalid,
  output logic              rx_tready,
  input  logic              rx_tlast,
  input  logic              rx_tuser,

  // Transmit stream to the MAC
  output logic [DATA_W-1:0] tx_tdata,
  output logic [KEEP_W-1:0] tx_tkeep,
  output logic              tx_tvalid,
  input  logic              tx_tready,
  output logic              tx_tlast,
  output logic              tx_tuser,

  output logic [7:0]        led
);

  axis_if rx_if ();
  axis_if link [FIFO_REGS+1] ();
  axis_if tx_if ();

  assign rx_if.tdata  = rx_tdata;
  assign rx_if.tkeep  = rx_tkeep;
  assign rx_if.tvalid = rx_tvalid;
  assign rx_if.tlast  = rx_tlast;
  assign rx_if.tuser  = rx_tuser;
  assign rx_tready    = rx_if.tready;

  udp_port_filter udp_port_filter_inst (
    .clk   (clk),
    .rst   (rst),
    .in_s  (rx_if),
    .out_m (link[0])
  );

  // Timing slices on the return path
  for (genvar g = 0; g < FIFO_REGS; g++) begin : g_stage
    axis_reg_stage axis_reg_stage_inst (
      .clk   (clk),
      .rst   (rst),
      .in_s  (link[g]),
      .out_m (link[g+1])
    );
  end

  loopback_responder loopback_responder_inst (
    .clk   (clk),
    .rst   (rst),
    .in_s  (link[FIFO_REGS]),
    .out_m (tx_if),
    .led   (led)
  );

  assign tx_tdata     = tx_if.tdata;
  assign tx_tkeep     = tx_if.tkeep;
  assign tx_tvalid    = tx_if.tvalid;
  assign tx_tlast     = tx_if.tlast;
  assign tx_tuser     = tx_if.tuser;
  assign tx_if.tready = tx_tready;

endmodule

// ==== verif/tb_udp_loopback.sv ====
// ========================================
// Self-checking testbench whose expected frames follow the address swap rule
// Payload and tx_tready stalls come from a 16-bit Galois LFSR with seed 73
// ========================================
`timescale 1ns/1ps

module tb_udp_loopback import udp_loopback_pkg::*; ();

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic              last;
    logic              user;
  } beat_t;

  logic              clk;
  logic              rst;
  logic [DATA_W-1:0] rx_tdata;
  logic [KEEP_W-1:0] rx_tkeep;
  logic              rx_tvalid;
  logic              rx_tready;
  logic              rx_tlast;
  logic              rx_tuser;
  logic [DATA_W-1:0] tx_tdata;
  logic [KEEP_W-1:0] tx_tkeep;
  logic              tx_tvalid;
  logic              tx_tready;
  logic              tx_tlast;
  logic              tx_tuser;
  logic [7:0]        led;

  beat_t       exp_q[$];
  beat_t       head;
  logic        head_valid;
  logic [7:0]  exp_led;
  logic        tx_first;
  logic        tx_fire;
  logic        rx_fire;
  logic        rx_stall;
  logic [15:0] pay_lfsr;
  logic [15:0] rdy_lfsr;
  int          ready_mode;
  string       test_name;

  udp_loopback_top udp_loopback_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Handshakes seen at the rising edge and read back on the falling edge
  always @(posedge clk) begin
    tx_fire  <= !rst && tx_tvalid && tx_tready;
    rx_fire  <= !rst && rx_tvalid && rx_tready;
    rx_stall <= !rst && rx_tvalid && !rx_tready;
  end

  // Mode 0 keeps tready high, 1 makes it random and 2 holds it low
  always @(negedge clk) begin
    if (ready_mode == 1) begin
      tx_tready = rdy_lfsr[0];
      rdy_lfsr  = lfsr_step(rdy_lfsr);
    end else begin
      tx_tready = (ready_mode == 0);
    end
  end

  // Retire the beat that left at the last rising edge
  always @(negedge clk) begin
    if (tx_fire && head_valid) begin
      if (tx_first) begin
        exp_led = head.data[8*HDR_BYTES +: 8];
      end
      tx_first = head.last;
      void'(exp_q.pop_front());
      refresh_head();
    end
  end

  a_tx_expected: assert property (
    @(posedge clk) disable iff (rst)
    (tx_tvalid && tx_tready) |-> head_valid
  ) else report_and_stop($sformatf("%s: tx beat came out with no frame pending", test_name));

  a_tx_beat: assert property (
    @(posedge clk) disable iff (rst)
    (tx_tvalid && tx_tready && head_valid) |->
      (tx_tdata == head.data && tx_tkeep == head.keep &&
       tx_tlast == head.last && tx_tuser == head.user)
  ) else report_and_stop($sformatf(
    "error %s: tx beat expected %h keep %h last %b user %b actual %h keep %h last %b user %b",
    test_name, head.data, head.keep, head.last, head.user, $sampled(tx_tdata),
    $sampled(tx_tkeep), $sampled(tx_tlast), $sampled(tx_tuser)));

  a_tx_stable: assert property (
    @(posedge clk) disable iff (rst)
    (tx_tvalid && !tx_tready) |=>
      (tx_tvalid && $stable(tx_tdata) && $stable(tx_tkeep) && $stable(tx_tlast) &&
       $stable(tx_tuser))
  ) else report_and_stop($sformatf("%s: stalled tx beat changed or vanished", test_name));

  a_reset_idle: assert property (
    @(posedge clk) rst |=> (!tx_tvalid && led == 8'd0)
  ) else report_and_stop($sformatf("error reset: tx_tvalid/led expected 0/00 actual %b/%h",
                                   $sampled(tx_tvalid), $sampled(led)));

  a_led: assert property (
    @(posedge clk) disable iff (rst)
    led == exp_led
  ) else report_and_stop($sformatf("error %s: led expected %h actual %h",
                                   test_name, exp_led, $sampled(led)));

  task automatic report_and_stop(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  // Taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v        = {v[30:0], pay_lfsr[0]};
      pay_lfsr = lfsr_step(pay_lfsr);
    end
    return v;
  endfunction

  // Fields are contiguous, so whole byte ranges trade places
  function automatic logic [DATA_W-1:0] expect_hdr(input logic [DATA_W-1:0] d);
    logic [DATA_W-1:0] r;
    r = d;
    r[8*OFS_DST_MAC +: 48]  = d[8*OFS_SRC_MAC +: 48];
    r[8*OFS_SRC_MAC +: 48]  = d[8*OFS_DST_MAC +: 48];
    r[8*OFS_SRC_IP +: 32]   = d[8*OFS_DST_IP +: 32];
    r[8*OFS_DST_IP +: 32]   = d[8*OFS_SRC_IP +: 32];
    r[8*OFS_SRC_PORT +: 16] = d[8*OFS_DST_PORT +: 16];
    r[8*OFS_DST_PORT +: 16] = d[8*OFS_SRC_PORT +: 16];
    return r;
  endfunction

  function automatic void refresh_head();
    head_valid = (exp_q.size() > 0);
    if (head_valid) begin
      head = exp_q[0];
    end
  endfunction

  task automatic drive_beat(input beat_t b);
    int waited;
    waited    = 0;
    rx_tdata  = b.data;
    rx_tkeep  = b.keep;
    rx_tlast  = b.last;
    rx_tuser  = b.user;
    rx_tvalid = 1'b1;
    do begin
      @(negedge clk);
      waited++;
    end while (!rx_fire && waited < 500);
    if (!rx_fire) begin
      report_and_stop($sformatf("%s: rx beat not accepted within 500 cycles", test_name));
    end else begin
      rx_tvalid = 1'b0;
    end
  endtask

  // first_bytes sets tkeep of a single-beat frame
  task automatic send_frame(input logic [15:0] etype, input logic [7:0] proto,
                            input logic [15:0] dport, input int nbeats,
                            input int first_bytes, input bit expect_out);
    beat_t       beats[$];
    beat_t       b;
    beat_t       e;
    logic [31:0] rb;
    int          i;
    int          j;
    int          nbytes;
    for (i = 0; i < nbeats; i++) begin
      for (j = 0; j < KEEP_W; j++) begin
        rb = take_bits(8);
        b.data[8*j +: 8] = rb[7:0];
      end
      if (i == 0) begin
        // Only the judged fields are fixed and the rest of the header is random
        b.data[8*OFS_ETHERTYPE +: 16] = {etype[7:0], etype[15:8]};
        b.data[8*OFS_IP_PROTO +: 8]   = proto;
        b.data[8*OFS_DST_PORT +: 16]  = {dport[7:0], dport[15:8]};
      end
      if (nbeats == 1) begin
        nbytes = first_bytes;
      end else if (i == nbeats - 1) begin
        rb     = take_bits(6);
        nbytes = int'(rb[5:0]) + 1;
      end else begin
        nbytes = KEEP_W;
      end
      for (j = 0; j < KEEP_W; j++) begin
        b.keep[j] = (j < nbytes);
      end
      rb     = take_bits(1);
      b.user = rb[0];
      b.last = (i == nbeats - 1);
      beats.push_back(b);
      if (expect_out) begin
        e = b;
        if (i == 0) begin
          e.data = expect_hdr(b.data);
        end
        exp_q.push_back(e);
      end
    end
    refresh_head();
    for (i = 0; i < nbeats; i++) begin
      drive_beat(beats[i]);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < 2000) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() > 0) begin
      report_and_stop($sformatf("%s: %0d expected tx beats never came out",
                                test_name, exp_q.size()));
    end
  endtask

  task automatic wait_rx_stall();
    int waited;
    waited = 0;
    while (!rx_stall && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (!rx_stall) begin
      report_and_stop($sformatf("%s: rx_tready never fell with tx stalled", test_name));
    end
  endtask

  initial begin
    int          k;
    int          nb;
    logic [31:0] rb;
    rst        = 1'b1;
    rx_tdata   = '0;
    rx_tkeep   = '0;
    rx_tvalid  = 1'b0;
    rx_tlast   = 1'b0;
    rx_tuser   = 1'b0;
    tx_tready  = 1'b1;
    pay_lfsr   = 16'd73;
    rdy_lfsr   = 16'd73;
    ready_mode = 0;
    head_valid = 1'b0;
    exp_led    = 8'd0;
    tx_first   = 1'b1;
    tx_fire    = 1'b0;
    rx_fire    = 1'b0;
    rx_stall   = 1'b0;
    test_name  = "reset";
    repeat (16) @(negedge clk);
    rst = 1'b0;

    test_name = "single_beat";
    send_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, LOOPBACK_PORT, 1, 60, 1'b1);
    wait_drain();

    test_name = "multi_beat";
    send_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, LOOPBACK_PORT, 3, KEEP_W, 1'b1);
    wait_drain();

    // Drops interleaved with matches
    test_name = "filter";
    send_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, LOOPBACK_PORT + 16'd1, 2, KEEP_W, 1'b0);
    send_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, LOOPBACK_PORT, 2, KEEP_W, 1'b1);
    send_frame(16'h86DD, IP_PROTO_UDP, LOOPBACK_PORT, 1, KEEP_W, 1'b0);
    send_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, LOOPBACK_PORT, 1, 50, 1'b1);
    send_frame(ETHERTYPE_IPV4, 8'd6, LOOPBACK_PORT, 3, KEEP_W, 1'b0);
    send_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, LOOPBACK_PORT, 3, KEEP_W, 1'b1);
    send_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, LOOPBACK_PORT, 1, HDR_BYTES - 1, 1'b0);
    send_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, LOOPBACK_PORT, 1, HDR_BYTES + 1, 1'b1);
    wait_drain();

    test_name  = "random_ready";
    ready_mode = 1;
    for (k = 0; k < 8; k++) begin
      rb = take_bits(2);
      nb = int'(rb[1:0]) + 1;
      send_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, LOOPBACK_PORT, nb, KEEP_W, 1'b1);
    end
    wait_drain();

    // More beats than the return path holds
    test_name  = "backpressure";
    ready_mode = 2;
    fork
      begin
        for (k = 0; k < 4; k++) begin
          send_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, LOOPBACK_PORT, 4, KEEP_W, 1'b1);
        end
      end
      begin
        wait_rx_stall();
        ready_mode = 1;
      end
    join
    wait_drain();

    // Idle time so that a duplicated beat would still show up
    test_name  = "idle";
    ready_mode = 0;
    repeat (20) @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== build.f ====
hdl/udp_loopback_pkg.sv
hdl/axis_if.sv
hdl/udp_port_filter.sv
hdl/axis_reg_stage.sv
hdl/loopback_responder.sv
hdl/udp_loopback_top.sv
verif/tb_udp_loopback.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP      ?= tb_udp_loopback
FILELIST ?= build.f
OBJ_DIR  ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)
